//--- design/baser_pkg.sv
// widths, sync header and block type codes, CRC constants and receive states for the 10GBASE-R receiver
`default_nettype none

package baser_pkg;

    typedef logic [63:0] word_t;
    typedef logic [7:0]  keep_t;
    typedef logic [1:0]  sync_hdr_t;
    typedef logic [7:0]  block_type_t;
    typedef logic [2:0]  lane_t;
    typedef logic [31:0] crc_t;
    typedef logic [15:0] pkt_len_t;

    localparam sync_hdr_t SYNC_DATA = 2'b10;
    localparam sync_hdr_t SYNC_CTRL = 2'b01;

    localparam block_type_t BLOCK_CTRL     = 8'h1e;
    localparam block_type_t BLOCK_OS_4     = 8'h2d;
    localparam block_type_t BLOCK_START_4  = 8'h33;
    localparam block_type_t BLOCK_OS_START = 8'h66;
    localparam block_type_t BLOCK_OS_04    = 8'h55;
    localparam block_type_t BLOCK_START_0  = 8'h78;
    localparam block_type_t BLOCK_OS_0     = 8'h4b;
    // terminate types, index is the lane of the /T/ character
    localparam block_type_t BLOCK_TERM_0   = 8'h87;
    localparam block_type_t BLOCK_TERM_1   = 8'h99;
    localparam block_type_t BLOCK_TERM_2   = 8'haa;
    localparam block_type_t BLOCK_TERM_3   = 8'hb4;
    localparam block_type_t BLOCK_TERM_4   = 8'hcc;
    localparam block_type_t BLOCK_TERM_5   = 8'hd2;
    localparam block_type_t BLOCK_TERM_6   = 8'he1;
    localparam block_type_t BLOCK_TERM_7   = 8'hff;

    // six preamble bytes and the SFD, lanes 1 to 7 of the start block
    localparam logic [55:0] PREAMBLE_SFD = 56'hd5_5555_5555_5555;

    // 04c11db7 in reflected form
    localparam crc_t CRC_POLY = 32'hedb8_8320;

    // entry k matches when the FCS ends in byte k of the word, zero padded above
    localparam logic [7:0][31:0] CRC_RESIDUE = {
        ~32'h2144df1c,
        ~32'hc622f71d,
        ~32'hb1c2a1a3,
        ~32'h9d6cdf7e,
        ~32'h6522df69,
        ~32'he60914ae,
        ~32'he38a6876,
        ~32'h6b87b1ec
    };

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PAYLOAD,
        RX_LAST
    } rx_state_t;

endpackage

`default_nettype wire

//--- design/block_decoder.sv
// block header and type checks, framing tracking, terminate detection and the input pipeline
`default_nettype none

module block_decoder (
    input  wire logic                 clk,
    input  wire logic                 reset_crc,
    input  wire baser_pkg::word_t     encoded_data,
    input  wire baser_pkg::sync_hdr_t encoded_hdr,
    output baser_pkg::word_t          word_d0,
    output baser_pkg::word_t          word_d1,
    output logic                      start_d1,
    output logic                      term_present,
    output logic                      term_first,
    output baser_pkg::lane_t          term_lane,
    output baser_pkg::lane_t          term_lane_d0,
    output logic                      framing_error,
    output logic                      stat_err_bad_block
);
    import baser_pkg::*;

    block_type_t block_type;
    logic        is_data;
    logic        is_ctrl;
    logic        type_ok;
    logic        term_hit;
    lane_t       lane_in;
    logic        term_in;
    logic        start_in;
    word_t       data_masked;
    logic        in_frame;
    logic        in_frame_next;
    logic        fe_in;
    logic        fe_d0;
    logic        fe_d1;
    logic        start_d0;

    assign block_type = encoded_data[7:0];
    assign is_data = encoded_hdr == SYNC_DATA;
    assign is_ctrl = encoded_hdr == SYNC_CTRL;
    assign term_in = is_ctrl && term_hit;
    // lane 0 start with a clean preamble only
    assign start_in = is_ctrl && block_type == BLOCK_START_0
        && encoded_data[63:8] == PREAMBLE_SFD;
    assign framing_error = fe_d0 || fe_d1;

    always_comb begin
        type_ok = 1'b1;
        term_hit = 1'b0;
        lane_in = '0;
        case (block_type)
            BLOCK_TERM_0: term_hit = 1'b1;
            BLOCK_TERM_1: {term_hit, lane_in} = {1'b1, 3'd1};
            BLOCK_TERM_2: {term_hit, lane_in} = {1'b1, 3'd2};
            BLOCK_TERM_3: {term_hit, lane_in} = {1'b1, 3'd3};
            BLOCK_TERM_4: {term_hit, lane_in} = {1'b1, 3'd4};
            BLOCK_TERM_5: {term_hit, lane_in} = {1'b1, 3'd5};
            BLOCK_TERM_6: {term_hit, lane_in} = {1'b1, 3'd6};
            BLOCK_TERM_7: {term_hit, lane_in} = {1'b1, 3'd7};
            BLOCK_CTRL, BLOCK_OS_4, BLOCK_START_4, BLOCK_OS_START,
            BLOCK_OS_04, BLOCK_START_0, BLOCK_OS_0: type_ok = 1'b1;
            default: type_ok = 1'b0;
        endcase
    end

    // drop the type byte, keep only the data lanes before /T/
    always_comb begin
        data_masked = encoded_data;
        if (term_in) begin
            data_masked = (encoded_data >> 8) & ~({64{1'b1}} << {lane_in, 3'b000});
        end
    end

    always_comb begin
        fe_in = in_frame;
        in_frame_next = 1'b0;
        if (is_data) begin
            fe_in = !in_frame;
            in_frame_next = in_frame;
        end else if (term_in) begin
            fe_in = !in_frame;
        end else if (is_ctrl && block_type == BLOCK_START_0) begin
            in_frame_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        word_d0 <= data_masked;
        word_d1 <= word_d0;
        term_lane <= lane_in;
        term_lane_d0 <= term_lane;
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            in_frame <= 1'b0;
            fe_d0 <= 1'b0;
            fe_d1 <= 1'b0;
            start_d0 <= 1'b0;
            start_d1 <= 1'b0;
            term_present <= 1'b0;
            term_first <= 1'b0;
            stat_err_bad_block <= 1'b0;
        end else begin
            in_frame <= in_frame_next;
            fe_d0 <= fe_in;
            fe_d1 <= fe_d0;
            start_d0 <= start_in;
            start_d1 <= start_d0;
            term_present <= term_in;
            term_first <= term_in && lane_in <= 3'd4;
            stat_err_bad_block <= !(is_data || (is_ctrl && type_ok));
        end
    end

endmodule

`default_nettype wire

//--- design/crc32_check.sv
// running CRC-32 over the pipeline word and the per-lane residue match flags
`default_nettype none

module crc32_check (
    input  wire logic             clk,
    input  wire logic             reset_crc,
    input  wire baser_pkg::word_t word_d0,
    input  wire logic             crc_clear,
    output logic [7:0]            crc_match,
    output logic [7:0]            crc_match_saved
);
    import baser_pkg::*;

    crc_t crc_state;
    crc_t crc_next;

    // bit-serial reflected Galois step, lane 0 bit 0 first
    function automatic crc_t crc_advance(crc_t state, word_t data);
        crc_t c;
        c = state;
        for (int i = 0; i < 64; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_advance(crc_state, word_d0);

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            crc_match[k] = crc_next == CRC_RESIDUE[k];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            crc_state <= '1;
            crc_match_saved <= '0;
        end else begin
            if (crc_clear) begin
                crc_state <= '1;
            end else begin
                crc_state <= crc_next;
            end
            crc_match_saved <= crc_match;
        end
    end

endmodule

`default_nettype wire

//--- design/rx_frame_fsm.sv
// receive FSM, length counter, oversize check, output stream registers and status pulses
`default_nettype none

module rx_frame_fsm (
    input  wire logic                clk,
    input  wire logic                reset_crc,
    input  wire baser_pkg::word_t    word_d1,
    input  wire logic                start_d1,
    input  wire logic                term_present,
    input  wire logic                term_first,
    input  wire baser_pkg::lane_t    term_lane,
    input  wire baser_pkg::lane_t    term_lane_d0,
    input  wire logic                framing_error,
    input  wire logic [7:0]          crc_match,
    input  wire logic [7:0]          crc_match_saved,
    input  wire logic                rx_enable,
    input  wire baser_pkg::pkt_len_t max_pkt_len,
    output logic                     crc_clear,
    output baser_pkg::word_t         rx_tdata,
    output baser_pkg::keep_t         rx_tkeep,
    output logic                     rx_tvalid,
    output logic                     rx_tlast,
    output logic                     rx_tuser,
    output baser_pkg::pkt_len_t      stat_pkt_len,
    output logic                     stat_pkt_good,
    output logic                     stat_pkt_bad,
    output logic                     stat_err_bad_fcs,
    output logic                     stat_err_oversize,
    output logic                     stat_err_framing
);
    import baser_pkg::*;

    localparam pkt_len_t WORD_BYTES = 16'd8;

    rx_state_t   state;
    rx_state_t   state_next;
    pkt_len_t    frame_len;
    pkt_len_t    len_next;
    pkt_len_t    len_limit;
    pkt_len_t    limit_next;
    logic        oversize;
    logic        oversize_next;
    logic [16:0] len_sum;
    pkt_len_t    len_add;
    logic        end_frame;
    logic        cut_frame;
    logic        crc_ok;
    keep_t       tkeep_next;
    logic        tvalid_next;
    logic        tlast_next;
    logic        tuser_next;
    pkt_len_t    stat_len_next;
    logic        good_next;
    logic        bad_next;
    logic        fcs_next;
    logic        framing_next;

    // count runs one word ahead, on the block behind word_d1
    assign len_sum = {1'b0, frame_len} + (term_present ? 17'(term_lane) : 17'(WORD_BYTES));
    assign len_add = len_sum[16] ? '1 : len_sum[15:0];

    always_comb begin
        state_next = state;
        crc_clear = 1'b0;
        len_next = frame_len;
        limit_next = len_limit;
        oversize_next = oversize;
        end_frame = 1'b0;
        cut_frame = 1'b0;
        crc_ok = 1'b0;
        tkeep_next = '0;
        tvalid_next = 1'b0;
        tlast_next = 1'b0;
        tuser_next = 1'b0;
        stat_len_next = '0;
        good_next = 1'b0;
        bad_next = 1'b0;
        fcs_next = 1'b0;
        framing_next = 1'b0;

        case (state)
            RX_IDLE: begin
                crc_clear = 1'b1;
                len_next = '0;
                limit_next = max_pkt_len;
                oversize_next = 1'b0;
                if (start_d1 && rx_enable) begin
                    crc_clear = 1'b0;
                    len_next = WORD_BYTES;
                    state_next = RX_PAYLOAD;
                end
            end
            RX_PAYLOAD: begin
                tvalid_next = 1'b1;
                tkeep_next = '1;
                len_next = len_add;
                oversize_next = oversize || len_add > len_limit;
                if (framing_error) begin
                    end_frame = 1'b1;
                    cut_frame = 1'b1;
                end else if (term_present && term_first) begin
                    // FCS ends in this beat
                    end_frame = 1'b1;
                    tkeep_next = 8'hff >> (3'd4 - term_lane);
                    if (term_lane == 3'd0) begin
                        crc_ok = crc_match_saved[7];
                    end else begin
                        crc_ok = crc_match[term_lane - 3'd1];
                    end
                end else if (term_present) begin
                    state_next = RX_LAST;
                end
            end
            RX_LAST: begin
                // trailing bytes of lane 5 to 7 terminates
                tvalid_next = 1'b1;
                tkeep_next = 8'hff >> (3'd4 - term_lane_d0);
                crc_ok = crc_match_saved[term_lane_d0 - 3'd1];
                end_frame = 1'b1;
            end
            default: state_next = RX_IDLE;
        endcase

        if (end_frame) begin
            crc_clear = 1'b1;
            state_next = RX_IDLE;
            tlast_next = 1'b1;
            tuser_next = cut_frame || !crc_ok || oversize_next;
            stat_len_next = len_next;
            good_next = !tuser_next;
            bad_next = tuser_next;
            fcs_next = !cut_frame && !crc_ok;
            framing_next = cut_frame;
        end
    end

    always_ff @(posedge clk) begin
        frame_len <= len_next;
        len_limit <= limit_next;
        oversize <= oversize_next;
        rx_tdata <= word_d1;
        rx_tkeep <= tkeep_next;
        rx_tlast <= tlast_next;
        rx_tuser <= tuser_next;
        stat_pkt_len <= stat_len_next;
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= RX_IDLE;
            rx_tvalid <= 1'b0;
            stat_pkt_good <= 1'b0;
            stat_pkt_bad <= 1'b0;
            stat_err_bad_fcs <= 1'b0;
            stat_err_oversize <= 1'b0;
            stat_err_framing <= 1'b0;
        end else begin
            state <= state_next;
            rx_tvalid <= tvalid_next;
            stat_pkt_good <= good_next;
            stat_pkt_bad <= bad_next;
            stat_err_bad_fcs <= fcs_next;
            stat_err_oversize <= end_frame && oversize_next;
            stat_err_framing <= framing_next;
        end
    end

endmodule

`default_nettype wire

//--- design/baser_rx.sv
// top level of the 10GBASE-R frame receiver, decoder, CRC checker and receive FSM
`default_nettype none

module baser_rx (
    input  wire logic                 clk,
    input  wire logic                 reset_crc,
    input  wire baser_pkg::word_t     encoded_data,
    input  wire baser_pkg::sync_hdr_t encoded_hdr,
    input  wire logic                 rx_enable,
    input  wire baser_pkg::pkt_len_t  max_pkt_len,
    output baser_pkg::word_t          rx_tdata,
    output baser_pkg::keep_t          rx_tkeep,
    output logic                      rx_tvalid,
    output logic                      rx_tlast,
    output logic                      rx_tuser,
    output baser_pkg::pkt_len_t       stat_pkt_len,
    output logic                      stat_pkt_good,
    output logic                      stat_pkt_bad,
    output logic                      stat_err_bad_fcs,
    output logic                      stat_err_oversize,
    output logic                      stat_err_framing,
    output logic                      stat_err_bad_block
);
    import baser_pkg::*;

    word_t      word_d0;
    word_t      word_d1;
    logic       start_d1;
    logic       term_present;
    logic       term_first;
    lane_t      term_lane;
    lane_t      term_lane_d0;
    logic       framing_error;
    logic       crc_clear;
    logic [7:0] crc_match;
    logic [7:0] crc_match_saved;

    block_decoder i_block_decoder (
        .clk,
        .reset_crc,
        .encoded_data,
        .encoded_hdr,
        .word_d0,
        .word_d1,
        .start_d1,
        .term_present,
        .term_first,
        .term_lane,
        .term_lane_d0,
        .framing_error,
        .stat_err_bad_block
    );

    crc32_check i_crc32_check (
        .clk,
        .reset_crc,
        .word_d0,
        .crc_clear,
        .crc_match,
        .crc_match_saved
    );

    rx_frame_fsm i_rx_frame_fsm (
        .clk,
        .reset_crc,
        .word_d1,
        .start_d1,
        .term_present,
        .term_first,
        .term_lane,
        .term_lane_d0,
        .framing_error,
        .crc_match,
        .crc_match_saved,
        .rx_enable,
        .max_pkt_len,
        .crc_clear,
        .rx_tdata,
        .rx_tkeep,
        .rx_tvalid,
        .rx_tlast,
        .rx_tuser,
        .stat_pkt_len,
        .stat_pkt_good,
        .stat_pkt_bad,
        .stat_err_bad_fcs,
        .stat_err_oversize,
        .stat_err_framing
    );

endmodule

`default_nettype wire

//--- bench/frame_model.svh
// LCG, reference CRC-32 and 66-bit block encoding helpers for the receiver testbench
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

// one byte of the reflected Ethernet CRC, bit 0 first
function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
    logic [31:0] r;
    r = c ^ {24'h0, b};
    for (int i = 0; i < 8; i++) begin
        if (r[0]) begin
            r = (r >> 1) ^ 32'hedb8_8320;
        end else begin
            r = r >> 1;
        end
    end
    return r;
endfunction

function automatic logic [31:0] frame_crc(input logic [7:0] bytes[$]);
    logic [31:0] c;
    c = 32'hffff_ffff;
    foreach (bytes[i]) begin
        c = crc_byte(c, bytes[i]);
    end
    return ~c;
endfunction

// six preamble bytes then the SFD, behind the start type
function automatic logic [63:0] start_block();
    return {8'hd5, {6{8'h55}}, 8'h78};
endfunction

function automatic logic [63:0] data_block(input logic [7:0] bytes[$], input int base);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < 8; i++) begin
        w[8*i +: 8] = bytes[base + i];
    end
    return w;
endfunction

function automatic logic [7:0] term_type(input int lane);
    case (lane)
        0: return 8'h87;
        1: return 8'h99;
        2: return 8'haa;
        3: return 8'hb4;
        4: return 8'hcc;
        5: return 8'hd2;
        6: return 8'he1;
        default: return 8'hff;
    endcase
endfunction

// data bytes sit in lanes 1 up to the /T/ lane, idle characters above
function automatic logic [63:0] term_block(input logic [7:0] bytes[$], input int base,
                                           input int lane);
    logic [63:0] w;
    w = '0;
    w[7:0] = term_type(lane);
    for (int i = 0; i < lane; i++) begin
        w[8*(i+1) +: 8] = bytes[base + i];
    end
    return w;
endfunction

`endif

//--- bench/baser_rx_tb.sv
// testbench for the 10GBASE-R frame receiver, table driven frames, collector and checks
`default_nettype none

module baser_rx_tb;
    import baser_pkg::*;
    `include "frame_model.svh"

    localparam int CLK_PERIOD = 4;
    localparam int DRIVE_DELAY = 1;
    localparam int RESET_CYCLES = 3;
    localparam int DONE_TIMEOUT = 200;
    localparam int QUIET_CYCLES = 40;
    localparam int FRAME_GAP = 4;
    localparam int NUM_ROWS = 14;
    localparam logic [31:0] SEED = 32'h5af8_5f6f;

    localparam int FAULT_NONE = 0;
    localparam int FAULT_FCS = 1;
    localparam int FAULT_CTRL = 2;
    localparam int FAULT_BLOCK = 3;

    typedef struct {
        int   payload_len;
        int   max_len;
        logic enable;
        int   fault;
        logic exp_tuser;
        logic exp_good;
        logic exp_bad;
        logic exp_fcs;
        logic exp_over;
        logic exp_framing;
        logic exp_block;
        int   exp_len;
    } row_t;

    logic      clk;
    logic      reset_crc;
    word_t     encoded_data;
    sync_hdr_t encoded_hdr;
    logic      rx_enable;
    pkt_len_t  max_pkt_len;
    word_t     rx_tdata;
    keep_t     rx_tkeep;
    logic      rx_tvalid;
    logic      rx_tlast;
    logic      rx_tuser;
    pkt_len_t  stat_pkt_len;
    logic      stat_pkt_good;
    logic      stat_pkt_bad;
    logic      stat_err_bad_fcs;
    logic      stat_err_oversize;
    logic      stat_err_framing;
    logic      stat_err_bad_block;

    row_t        table_rows[NUM_ROWS];
    logic [31:0] lcg_state;
    logic [7:0]  payload[$];
    logic [7:0]  frame[$];
    logic [7:0]  got_bytes[$];
    int          beat_count;
    logic        frame_done;
    logic        got_tuser;
    pkt_len_t    got_len;
    logic        seen_good;
    logic        seen_bad;
    logic        seen_fcs;
    logic        seen_over;
    logic        seen_framing;
    logic        seen_block;
    int          check_count;
    int          error_count;
    int          row_errors;

    baser_rx i_baser_rx (
        .clk,
        .reset_crc,
        .encoded_data,
        .encoded_hdr,
        .rx_enable,
        .max_pkt_len,
        .rx_tdata,
        .rx_tkeep,
        .rx_tvalid,
        .rx_tlast,
        .rx_tuser,
        .stat_pkt_len,
        .stat_pkt_good,
        .stat_pkt_bad,
        .stat_err_bad_fcs,
        .stat_err_oversize,
        .stat_err_framing,
        .stat_err_bad_block
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // sampled mid-cycle, away from the rising edge
    always @(negedge clk) begin
        if (rx_tvalid) begin
            beat_count++;
            for (int i = 0; i < 8; i++) begin
                if (rx_tkeep[i]) begin
                    got_bytes.push_back(rx_tdata[8*i +: 8]);
                end
            end
            if (rx_tlast) begin
                frame_done = 1'b1;
                got_tuser = rx_tuser;
                got_len = stat_pkt_len;
            end
        end
        seen_good = seen_good | stat_pkt_good;
        seen_bad = seen_bad | stat_pkt_bad;
        seen_fcs = seen_fcs | stat_err_bad_fcs;
        seen_over = seen_over | stat_err_oversize;
        seen_framing = seen_framing | stat_err_framing;
        seen_block = seen_block | stat_err_bad_block;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            row_errors++;
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic send_block(input sync_hdr_t hdr, input word_t data);
        @(posedge clk);
        #DRIVE_DELAY;
        encoded_hdr = hdr;
        encoded_data = data;
    endtask

    task automatic send_idles(input int count);
        for (int i = 0; i < count; i++) begin
            send_block(SYNC_CTRL, {56'h0, BLOCK_CTRL});
        end
    endtask

    task automatic clear_collector();
        got_bytes.delete();
        beat_count = 0;
        frame_done = 1'b0;
        got_tuser = 1'b0;
        got_len = '0;
        seen_good = 1'b0;
        seen_bad = 1'b0;
        seen_fcs = 1'b0;
        seen_over = 1'b0;
        seen_framing = 1'b0;
        seen_block = 1'b0;
    endtask

    task automatic fill_table();
        // lengths 60 to 67 put the /T/ character in every lane
        for (int i = 0; i < 8; i++) begin
            table_rows[i] = '{60 + i, 1518, 1'b1, FAULT_NONE,
                              1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 64 + i};
        end
        table_rows[8] = '{100, 1518, 1'b1, FAULT_FCS,
                          1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 104};
        table_rows[9] = '{100, 64, 1'b1, FAULT_NONE,
                          1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 104};
        // length of a cut frame is not checked
        table_rows[10] = '{100, 1518, 1'b1, FAULT_CTRL,
                           1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 0};
        table_rows[11] = '{61, 1518, 1'b1, FAULT_BLOCK,
                           1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 65};
        table_rows[12] = '{64, 1518, 1'b0, FAULT_NONE,
                           1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 0};
        table_rows[13] = '{62, 1518, 1'b1, FAULT_NONE,
                           1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 66};
    endtask

    task automatic build_frame(input row_t row);
        logic [31:0] fcs;
        payload.delete();
        for (int i = 0; i < row.payload_len; i++) begin
            lcg_state = lcg_step(lcg_state);
            payload.push_back(lcg_state[23:16]);
        end
        fcs = frame_crc(payload);
        frame = payload;
        for (int i = 0; i < 4; i++) begin
            frame.push_back(fcs[8*i +: 8]);
        end
        if (row.fault == FAULT_FCS) begin
            frame[row.payload_len] = frame[row.payload_len] ^ 8'h01;
        end
    endtask

    task automatic send_frame(input row_t row);
        int full_blocks;
        int lane;
        full_blocks = frame.size() / 8;
        lane = frame.size() % 8;
        send_idles(FRAME_GAP);
        if (row.fault == FAULT_BLOCK) begin
            send_block(SYNC_CTRL, 64'h0);
            send_idles(1);
        end
        send_block(SYNC_CTRL, start_block());
        for (int b = 0; b < full_blocks; b++) begin
            if (row.fault == FAULT_CTRL && b == 3) begin
                send_idles(1);
            end
            send_block(SYNC_DATA, data_block(frame, 8 * b));
        end
        send_block(SYNC_CTRL, term_block(frame, 8 * full_blocks, lane));
        send_idles(FRAME_GAP);
    endtask

    task automatic check_flags(input row_t row);
        check_value("stat_pkt_good", seen_good, row.exp_good);
        check_value("stat_pkt_bad", seen_bad, row.exp_bad);
        check_value("stat_err_bad_fcs", seen_fcs, row.exp_fcs);
        check_value("stat_err_oversize", seen_over, row.exp_over);
        check_value("stat_err_framing", seen_framing, row.exp_framing);
        check_value("stat_err_bad_block", seen_block, row.exp_block);
    endtask

    initial begin
        int cycles;
        row_t row;
        encoded_hdr = SYNC_CTRL;
        encoded_data = {56'h0, BLOCK_CTRL};
        rx_enable = 1'b1;
        max_pkt_len = 16'd1518;
        reset_crc = 1'b1;
        lcg_state = SEED;
        check_count = 0;
        error_count = 0;
        clear_collector();
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_crc = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = table_rows[r];
            row_errors = 0;
            @(posedge clk);
            #DRIVE_DELAY;
            rx_enable = row.enable;
            max_pkt_len = 16'(row.max_len);
            clear_collector();
            build_frame(row);
            send_frame(row);

            if (row.enable) begin
                cycles = 0;
                while (!frame_done && cycles < DONE_TIMEOUT) begin
                    @(posedge clk);
                    cycles++;
                end
                if (!frame_done) begin
                    $display("row %0d: no tlast beat within %0d cycles", r, DONE_TIMEOUT);
                    error_count++;
                    row_errors++;
                end else begin
                    check_value("rx_tuser", got_tuser, row.exp_tuser);
                    check_flags(row);
                    if (row.exp_len != 0) begin
                        check_value("stat_pkt_len", got_len, row.exp_len);
                    end
                    if (row.fault == FAULT_CTRL) begin
                        // cut frame ends before the payload does
                        check_value("frame cut early", got_bytes.size() < payload.size(), 1);
                    end else begin
                        check_value("byte count", got_bytes.size(), payload.size());
                    end
                    for (int i = 0; i < got_bytes.size() && i < payload.size(); i++) begin
                        check_value($sformatf("rx byte %0d", i), got_bytes[i], payload[i]);
                    end
                end
            end else begin
                // disabled receiver must stay silent
                cycles = 0;
                while (cycles < QUIET_CYCLES) begin
                    @(posedge clk);
                    cycles++;
                end
                check_value("rx_tvalid beats", beat_count, 0);
                check_flags(row);
            end
            $display("row %0d: payload %0d bytes, %s", r, row.payload_len,
                     row_errors == 0 ? "pass" : "FAIL");
        end

        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- baser_rx.f
+incdir+bench
design/baser_pkg.sv
design/block_decoder.sv
design/crc32_check.sv
design/rx_frame_fsm.sv
design/baser_rx.sv
bench/baser_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the baser_rx testbench with Verilator.
set -u

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f baser_rx.f \
    --top-module baser_rx_tb \
    -o sim_baser_rx > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_baser_rx > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -qx "Everything OK" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
